// ==== source/mem_pkg.sv ====
package mem_pkg;

    // Datapath widths
    localparam int NB_DATA    = 32;     // Data word
    localparam int NB_ADDR    = 32;     // ALU result, used as address
    localparam int NB_PC      = 32;     // Program counter
    localparam int NB_REG     = 5;      // Register bank index

    // Data memory geometry
    localparam int NB_DM_ADDR = 5;      // Word index into data memory
    localparam int MEM_DEPTH  = 32;     // Words in data memory

    // Subword sizes for loads and stores
    localparam int NB_HALF    = 16;     // Halfword
    localparam int NB_BYTE    = 8;      // Byte

endpackage

// ==== source/mem_buses.sv ====
`timescale 1ns/1ps

// Controller side of the data memory, no handshake
interface dm_bus_if;
    import mem_pkg::*;

    logic                  enable;          // Memory enable from datapath
    logic                  mem_write;       // Store strobe
    logic                  mem_read;        // Load or debug read
    logic [NB_DM_ADDR-1:0] address;         // Word index
    logic [NB_DATA-1:0]    write_data;      // Masked store data
    logic [NB_DATA-1:0]    read_data;       // Raw memory word

    // Address and mem_read come from the stage's debug select
    modport controller (
        output enable,
        output mem_write,
        output write_data,
        input  read_data
    );

    modport memory (
        input  enable,
        input  mem_write,
        input  mem_read,
        input  address,
        input  write_data,
        output read_data
    );
endinterface

// Writeback fields from MEM to the MEM/WB register
interface wb_bus_if;
    import mem_pkg::*;

    logic               reg_write;          // WB stage flag
    logic               mem_to_reg;         // WB stage flag
    logic               r31_ctrl;           // Link register select
    logic               hlt;                // Halt marker
    logic [NB_DATA-1:0] mem_data;           // Extended load data
    logic [NB_ADDR-1:0] alu_result;         // R type and store results
    logic [NB_REG-1:0]  selected_reg;       // rd or rt
    logic [NB_PC-1:0]   pc;

    modport stage (
        output reg_write, mem_to_reg, r31_ctrl, hlt,
        output mem_data, alu_result, selected_reg, pc
    );

    modport latch (
        input  reg_write, mem_to_reg, r31_ctrl, hlt,
        input  mem_data, alu_result, selected_reg, pc
    );
endinterface

// ==== source/data_mem_controller.sv ====
`timescale 1ns/1ps

module data_mem_controller (
    input  logic                        i_signed,       // Sign extend loads
    input  logic                        i_mem_write,
    input  logic                        i_word_en,
    input  logic                        i_halfword_en,
    input  logic                        i_byte_en,
    input  logic                        i_enable,
    input  logic [mem_pkg::NB_DATA-1:0] i_write_data,   // Register B from EX
    output logic [mem_pkg::NB_DATA-1:0] o_read_data,    // To WB or debug unit
    dm_bus_if.controller                dm
);
    import mem_pkg::*;

    logic [NB_HALF-1:0] load_half;
    logic [NB_BYTE-1:0] load_byte;

    assign dm.enable    = i_enable;
    assign dm.mem_write = i_mem_write;

    assign load_half = dm.read_data[NB_HALF-1:0];
    assign load_byte = dm.read_data[NB_BYTE-1:0];

    // Store path keeps only the low part for subword sizes
    always_comb begin
        if (i_word_en) begin
            dm.write_data = i_write_data;
        end else if (i_halfword_en) begin
            dm.write_data = {{(NB_DATA-NB_HALF){1'b0}}, i_write_data[NB_HALF-1:0]};
        end else if (i_byte_en) begin
            dm.write_data = {{(NB_DATA-NB_BYTE){1'b0}}, i_write_data[NB_BYTE-1:0]};
        end else begin
            dm.write_data = i_write_data;       // No size given, full word
        end
    end

    // Load path extends the low byte or halfword of the memory word
    always_comb begin
        if (i_word_en) begin
            o_read_data = dm.read_data;
        end else if (i_halfword_en) begin
            if (i_signed) begin
                o_read_data = {{(NB_DATA-NB_HALF){load_half[NB_HALF-1]}}, load_half};
            end else begin
                o_read_data = {{(NB_DATA-NB_HALF){1'b0}}, load_half};
            end
        end else if (i_byte_en) begin
            if (i_signed) begin
                o_read_data = {{(NB_DATA-NB_BYTE){load_byte[NB_BYTE-1]}}, load_byte};
            end else begin
                o_read_data = {{(NB_DATA-NB_BYTE){1'b0}}, load_byte};
            end
        end else begin
            o_read_data = dm.read_data;
        end
    end

endmodule

// ==== source/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
    input  logic     i_clock,
    dm_bus_if.memory dm
);
    import mem_pkg::*;

    logic [NB_DATA-1:0] mem [MEM_DEPTH];    // Register file storage

    // Stores land on the edge, visible to a load the next cycle
    always_ff @(posedge i_clock) begin
        if (dm.enable && dm.mem_write) begin
            mem[dm.address] <= dm.write_data;
        end
    end

    // Read gated by mem_read, zero otherwise
    assign dm.read_data = dm.mem_read ? mem[dm.address] : '0;

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                           i_clock,
    input  logic                           i_du_flag,           // Debug unit owns the port
    input  logic                           i_du_read_enable,    // Debug unit
    input  logic [mem_pkg::NB_DM_ADDR-1:0] i_du_read_address,   // Debug unit
    input  logic                           i_dm_enable,
    input  logic                           i_signed,
    input  logic                           i_mem_read,
    input  logic                           i_mem_write,
    input  logic                           i_word_en,
    input  logic                           i_halfword_en,
    input  logic                           i_byte_en,
    input  logic                           i_branch,
    input  logic                           i_zero,              // ALU zero flag
    input  logic [mem_pkg::NB_PC-1:0]      i_branch_addr,
    input  logic [mem_pkg::NB_ADDR-1:0]    i_alu_result,        // Also the memory address
    input  logic [mem_pkg::NB_DATA-1:0]    i_write_data,
    input  logic [mem_pkg::NB_REG-1:0]     i_selected_reg,
    input  logic                           i_reg_write,
    input  logic                           i_mem_to_reg,
    input  logic                           i_r31_ctrl,
    input  logic [mem_pkg::NB_PC-1:0]      i_pc,
    input  logic                           i_hlt,
    output logic                           o_branch_taken,      // IF mux select
    output logic [mem_pkg::NB_PC-1:0]      o_branch_addr,
    output logic [mem_pkg::NB_DATA-1:0]    o_mem_data,          // Extended load data
    wb_bus_if.stage                        wb
);
    import mem_pkg::*;

    dm_bus_if dm_bus ();

    // Debug unit takes over read flag and address
    always_comb begin
        if (i_du_flag) begin
            dm_bus.mem_read = i_du_read_enable;
            dm_bus.address  = i_du_read_address;
        end else begin
            dm_bus.mem_read = i_mem_read;
            dm_bus.address  = i_alu_result[NB_DM_ADDR-1:0];   // Word index only
        end
    end

    data_mem_controller u_controller (
        .i_signed      (i_signed),
        .i_mem_write   (i_mem_write),
        .i_word_en     (i_word_en),
        .i_halfword_en (i_halfword_en),
        .i_byte_en     (i_byte_en),
        .i_enable      (i_dm_enable),
        .i_write_data  (i_write_data),
        .o_read_data   (o_mem_data),
        .dm            (dm_bus)
    );

    data_memory u_memory (
        .i_clock (i_clock),
        .dm      (dm_bus)
    );

    assign o_branch_taken = i_zero & i_branch;
    assign o_branch_addr  = i_branch_addr;

    // Fields on to WB
    assign wb.reg_write    = i_reg_write;
    assign wb.mem_to_reg   = i_mem_to_reg;
    assign wb.r31_ctrl     = i_r31_ctrl;
    assign wb.hlt          = i_hlt;
    assign wb.mem_data     = o_mem_data;
    assign wb.alu_result   = i_alu_result;
    assign wb.selected_reg = i_selected_reg;
    assign wb.pc           = i_pc;

endmodule

// ==== source/mem_wb_register.sv ====
`timescale 1ns/1ps

module mem_wb_register (
    input  logic                        i_clock,
    input  logic                        i_reset,
    wb_bus_if.latch                     wb,
    output logic                        o_reg_write,
    output logic                        o_mem_to_reg,
    output logic                        o_r31_ctrl,
    output logic                        o_hlt,
    output logic [mem_pkg::NB_DATA-1:0] o_mem_data,
    output logic [mem_pkg::NB_ADDR-1:0] o_alu_result,
    output logic [mem_pkg::NB_REG-1:0]  o_selected_reg,
    output logic [mem_pkg::NB_PC-1:0]   o_pc
);

    // Control flags, cleared so WB stays idle after reset
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_reg_write  <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_r31_ctrl   <= 1'b0;
            o_hlt        <= 1'b0;
        end else begin
            o_reg_write  <= wb.reg_write;
            o_mem_to_reg <= wb.mem_to_reg;
            o_r31_ctrl   <= wb.r31_ctrl;
            o_hlt        <= wb.hlt;
        end
    end

    // Data fields
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_mem_data     <= '0;
            o_alu_result   <= '0;
            o_selected_reg <= '0;
            o_pc           <= '0;
        end else begin
            o_mem_data     <= wb.mem_data;
            o_alu_result   <= wb.alu_result;
            o_selected_reg <= wb.selected_reg;
            o_pc           <= wb.pc;
        end
    end

endmodule

// ==== source/mem_pipeline_top.sv ====
`timescale 1ns/1ps

module mem_pipeline_top (
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_du_flag,
    input  logic                           i_du_read_enable,
    input  logic [mem_pkg::NB_DM_ADDR-1:0] i_du_read_address,
    input  logic                           i_dm_enable,
    input  logic                           i_signed,
    input  logic                           i_mem_read,
    input  logic                           i_mem_write,
    input  logic                           i_word_en,
    input  logic                           i_halfword_en,
    input  logic                           i_byte_en,
    input  logic                           i_branch,
    input  logic                           i_zero,
    input  logic [mem_pkg::NB_PC-1:0]      i_branch_addr,
    input  logic [mem_pkg::NB_ADDR-1:0]    i_alu_result,
    input  logic [mem_pkg::NB_DATA-1:0]    i_write_data,
    input  logic [mem_pkg::NB_REG-1:0]     i_selected_reg,
    input  logic                           i_reg_write,
    input  logic                           i_mem_to_reg,
    input  logic                           i_r31_ctrl,
    input  logic [mem_pkg::NB_PC-1:0]      i_pc,
    input  logic                           i_hlt,
    output logic                           o_branch_taken,
    output logic [mem_pkg::NB_PC-1:0]      o_branch_addr,
    output logic [mem_pkg::NB_DATA-1:0]    o_du_mem_data,       // Same cycle load data
    output logic                           o_wb_reg_write,
    output logic                           o_wb_mem_to_reg,
    output logic                           o_wb_r31_ctrl,
    output logic                           o_wb_hlt,
    output logic [mem_pkg::NB_DATA-1:0]    o_wb_mem_data,
    output logic [mem_pkg::NB_ADDR-1:0]    o_wb_alu_result,
    output logic [mem_pkg::NB_REG-1:0]     o_wb_selected_reg,
    output logic [mem_pkg::NB_PC-1:0]      o_wb_pc
);

    wb_bus_if wb_bus ();

    mem_stage u_mem_stage (
        .i_clock           (i_clock),
        .i_du_flag         (i_du_flag),
        .i_du_read_enable  (i_du_read_enable),
        .i_du_read_address (i_du_read_address),
        .i_dm_enable       (i_dm_enable),
        .i_signed          (i_signed),
        .i_mem_read        (i_mem_read),
        .i_mem_write       (i_mem_write),
        .i_word_en         (i_word_en),
        .i_halfword_en     (i_halfword_en),
        .i_byte_en         (i_byte_en),
        .i_branch          (i_branch),
        .i_zero            (i_zero),
        .i_branch_addr     (i_branch_addr),
        .i_alu_result      (i_alu_result),
        .i_write_data      (i_write_data),
        .i_selected_reg    (i_selected_reg),
        .i_reg_write       (i_reg_write),
        .i_mem_to_reg      (i_mem_to_reg),
        .i_r31_ctrl        (i_r31_ctrl),
        .i_pc              (i_pc),
        .i_hlt             (i_hlt),
        .o_branch_taken    (o_branch_taken),
        .o_branch_addr     (o_branch_addr),
        .o_mem_data        (o_du_mem_data),
        .wb                (wb_bus)
    );

    mem_wb_register u_mem_wb (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .wb             (wb_bus),
        .o_reg_write    (o_wb_reg_write),
        .o_mem_to_reg   (o_wb_mem_to_reg),
        .o_r31_ctrl     (o_wb_r31_ctrl),
        .o_hlt          (o_wb_hlt),
        .o_mem_data     (o_wb_mem_data),
        .o_alu_result   (o_wb_alu_result),
        .o_selected_reg (o_wb_selected_reg),
        .o_pc           (o_wb_pc)
    );

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic o_clock,
    output logic o_reset
);
    localparam time HALF_PERIOD  = 5ns;     // 10 ns period
    localparam int  RESET_CYCLES = 5;

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD) o_clock = ~o_clock;
    end

    // Released on a rising edge, like any other synchronous input
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_reset <= 1'b0;
    end

endmodule

// ==== testbench/mem_pipeline_props.sv ====
`timescale 1ns/1ps

module mem_pipeline_props (
    input logic                      i_clock,
    input logic                      i_reset,
    input logic                      i_branch,
    input logic                      i_zero,
    input logic [mem_pkg::NB_PC-1:0] i_pc,
    input logic                      o_branch_taken,
    input logic                      o_wb_reg_write,
    input logic [mem_pkg::NB_PC-1:0] o_wb_pc
);

    a_branch_taken: assert property (@(posedge i_clock) o_branch_taken == (i_branch && i_zero))
        else $error("o_branch_taken differs from i_branch and i_zero");

    // WB stays idle for the cycle after any reset cycle
    a_reset_idle: assert property (@(posedge i_clock) i_reset |=> !o_wb_reg_write)
        else $error("o_wb_reg_write high one cycle after reset");

    a_pc_forward: assert property (@(posedge i_clock) !i_reset |=> o_wb_pc == $past(i_pc))
        else $error("o_wb_pc does not follow i_pc by one cycle");

endmodule

bind mem_pipeline_top mem_pipeline_props u_props (.*);

// ==== testbench/mem_pipeline_tb.sv ====
`timescale 1ns/1ps

module mem_pipeline_tb;
    import mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;           // Far above the length of all tests
    localparam int unsigned SEED  = 32'h6bb028e7;

    logic i_clock, i_reset;
    logic i_du_flag, i_du_read_enable, i_dm_enable, i_signed, i_mem_read, i_mem_write;
    logic i_word_en, i_halfword_en, i_byte_en, i_branch, i_zero;
    logic i_reg_write, i_mem_to_reg, i_r31_ctrl, i_hlt;
    logic [NB_DM_ADDR-1:0] i_du_read_address;
    logic [NB_PC-1:0]      i_branch_addr;
    logic [NB_ADDR-1:0]    i_alu_result;
    logic [NB_DATA-1:0]    i_write_data;
    logic [NB_REG-1:0]     i_selected_reg;
    logic [NB_PC-1:0]      i_pc;
    logic o_branch_taken, o_wb_reg_write, o_wb_mem_to_reg, o_wb_r31_ctrl, o_wb_hlt;
    logic [NB_PC-1:0]      o_branch_addr;
    logic [NB_DATA-1:0]    o_du_mem_data;
    logic [NB_DATA-1:0]    o_wb_mem_data;
    logic [NB_ADDR-1:0]    o_wb_alu_result;
    logic [NB_REG-1:0]     o_wb_selected_reg;
    logic [NB_PC-1:0]      o_wb_pc;

    int errors = 0;
    int cycles = 0;

    clock_gen u_clock_gen (.o_clock(i_clock), .o_reset(i_reset));

    mem_pipeline_top UUT (.*);

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Size is one-hot {word, halfword, byte}
    task automatic set_access(input logic wr, input logic rd, input logic [2:0] size,
                              input logic sgn, input logic [4:0] addr,
                              input logic [31:0] data);
        @(posedge i_clock);
        i_dm_enable  <= 1'b1;
        i_mem_write  <= wr;
        i_mem_read   <= rd;
        {i_word_en, i_halfword_en, i_byte_en} <= size;
        i_signed     <= sgn;
        i_alu_result <= 32'(addr);
        i_write_data <= data;
    endtask

    task automatic load_check(input logic [4:0] addr, input logic [2:0] size,
                              input logic sgn, input logic [31:0] expected);
        set_access(1'b0, 1'b1, size, sgn, addr, 32'h0);
        @(negedge i_clock);
        check("o_du_mem_data", expected, o_du_mem_data);
        @(negedge i_clock);
        check("o_wb_mem_data", expected, o_wb_mem_data);
    endtask

    task automatic test_reset();
        @(negedge i_clock);
        while (i_reset) begin
            check("o_wb_reg_write", 32'h0, 32'(o_wb_reg_write));
            check("o_wb_mem_to_reg", 32'h0, 32'(o_wb_mem_to_reg));
            check("o_wb_r31_ctrl", 32'h0, 32'(o_wb_r31_ctrl));
            check("o_wb_hlt", 32'h0, 32'(o_wb_hlt));
            @(negedge i_clock);
        end
        check("o_wb_reg_write", 32'h0, 32'(o_wb_reg_write));    // First cycle out of reset
        check("o_wb_mem_to_reg", 32'h0, 32'(o_wb_mem_to_reg));
        check("o_wb_r31_ctrl", 32'h0, 32'(o_wb_r31_ctrl));
        check("o_wb_hlt", 32'h0, 32'(o_wb_hlt));
    endtask

    task automatic test_word_access();
        logic [31:0] words [4];
        logic [31:0] pc;
        int i;
        for (i = 0; i < 4; i++) begin
            words[i] = $urandom();
            set_access(1'b1, 1'b0, 3'b100, 1'b0, 5'(i * 7 + 3), words[i]);
        end
        for (i = 0; i < 4; i++) begin
            pc = $urandom();
            set_access(1'b0, 1'b1, 3'b100, 1'b0, 5'(i * 7 + 3), 32'h0);
            i_pc           <= pc;
            i_selected_reg <= 5'(i + 8);
            i_reg_write    <= !i[1];        // Each flag gets its own pattern
            i_mem_to_reg   <= !i[0];
            i_r31_ctrl     <= i[0];
            i_hlt          <= i[1];
            @(negedge i_clock);
            check("o_du_mem_data", words[i], o_du_mem_data);
            @(negedge i_clock);
            check("o_wb_mem_data", words[i], o_wb_mem_data);
            check("o_wb_alu_result", 32'(i * 7 + 3), o_wb_alu_result);
            check("o_wb_pc", pc, o_wb_pc);
            check("o_wb_selected_reg", 32'(i + 8), 32'(o_wb_selected_reg));
            check("o_wb_reg_write", 32'(!i[1]), 32'(o_wb_reg_write));
            check("o_wb_mem_to_reg", 32'(!i[0]), 32'(o_wb_mem_to_reg));
            check("o_wb_r31_ctrl", 32'(i[0]), 32'(o_wb_r31_ctrl));
            check("o_wb_hlt", 32'(i[1]), 32'(o_wb_hlt));
        end
    endtask

    task automatic test_subword_access();
        logic [31:0] bval;
        logic [31:0] hval;
        bval = $urandom() | 32'h80;         // Low byte negative
        hval = $urandom() | 32'h8000;       // Low halfword negative
        set_access(1'b1, 1'b0, 3'b001, 1'b0, 5'd5, bval);
        set_access(1'b1, 1'b0, 3'b010, 1'b0, 5'd6, hval);
        load_check(5'd5, 3'b100, 1'b0, {24'h0, bval[7:0]});     // Stored zero-filled
        load_check(5'd5, 3'b001, 1'b1, {{24{bval[7]}}, bval[7:0]});
        load_check(5'd5, 3'b001, 1'b0, {24'h0, bval[7:0]});
        load_check(5'd6, 3'b100, 1'b0, {16'h0, hval[15:0]});
        load_check(5'd6, 3'b010, 1'b1, {{16{hval[15]}}, hval[15:0]});
        load_check(5'd6, 3'b010, 1'b0, {16'h0, hval[15:0]});
    endtask

    task automatic test_debug_read();
        logic [31:0] value;
        value = $urandom();
        set_access(1'b1, 1'b0, 3'b100, 1'b0, 5'd20, value);
        set_access(1'b0, 1'b1, 3'b100, 1'b0, 5'd9, 32'h0);     // Datapath aims elsewhere
        i_du_flag         <= 1'b1;
        i_du_read_enable  <= 1'b1;
        i_du_read_address <= 5'd20;
        @(negedge i_clock);
        check("o_du_mem_data", value, o_du_mem_data);
        @(posedge i_clock);
        i_du_read_enable <= 1'b0;
        @(negedge i_clock);
        check("o_du_mem_data", 32'h0, o_du_mem_data);
        @(posedge i_clock);
        i_du_flag <= 1'b0;
    endtask

    task automatic test_branch();
        logic [31:0] target;
        int k;
        for (k = 0; k < 4; k++) begin
            target = $urandom();
            @(posedge i_clock);
            {i_branch, i_zero} <= 2'(k);
            i_branch_addr      <= target;
            @(negedge i_clock);
            check("o_branch_taken", 32'(k == 3), 32'(o_branch_taken));
            check("o_branch_addr", target, o_branch_addr);
        end
    endtask

    always @(posedge i_clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        i_du_flag         <= 1'b0;
        i_du_read_enable  <= 1'b0;
        i_du_read_address <= '0;
        i_dm_enable       <= 1'b0;
        i_signed          <= 1'b0;
        i_mem_read        <= 1'b0;
        i_mem_write       <= 1'b0;
        {i_word_en, i_halfword_en, i_byte_en} <= 3'b100;
        {i_branch, i_zero} <= 2'b00;
        i_branch_addr     <= '0;
        i_alu_result      <= '0;
        i_write_data      <= '0;
        i_selected_reg    <= '0;
        i_pc              <= '0;
        {i_reg_write, i_mem_to_reg, i_r31_ctrl, i_hlt} <= 4'hf;  // Reset must hide these
        test_reset();
        test_word_access();
        test_subword_access();
        test_debug_read();
        test_branch();
        @(negedge i_clock);
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== mem_pipeline_top.f ====
source/mem_pkg.sv
source/mem_buses.sv
source/data_mem_controller.sv
source/data_memory.sv
source/mem_stage.sv
source/mem_wb_register.sv
source/mem_pipeline_top.sv
testbench/clock_gen.sv
testbench/mem_pipeline_props.sv
testbench/mem_pipeline_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MEM stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_pipeline_tb -f mem_pipeline_top.f > build.log 2>&1 \
    && ./obj_dir/Vmem_pipeline_tb > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
